/* bench/mf2_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mf2_checker (
	input  logic        clk_sys,
	input  logic        sample,   // Compare on this cycle
	input  logic        test_end, // Report the test in test_id
	input  logic [7:0]  test_id,
	input  logic [15:0] cpu_addr,
	input  logic        exp_nmi,
	input  logic        exp_en,
	input  logic [7:0]  exp_dout,
	input  logic        nmi,
	input  logic        mf2_en,
	input  logic        rom_en,
	input  logic        ram_en,
	input  logic [7:0]  dout,
	output int          mismatches,
	output int          tests_ok,
	output int          tests_bad
);

	int   test_errors;
	logic exp_rom, exp_ram;

	// ROM in the low 8 KB, RAM in the 8 KB above, only while paged in
	assign exp_rom = exp_en && (cpu_addr < 16'h2000);
	assign exp_ram = exp_en && (cpu_addr >= 16'h2000) && (cpu_addr < 16'h4000);

	task automatic compare(input string what, input logic [7:0] want, input logic [7:0] got);
		if (got !== want) begin
			$display("mismatch at %0d ns: test %0d %s expected %h, got %h",
				$time, test_id, what, want, got);
			test_errors++;
			mismatches++;
		end
	endtask

	initial begin
		test_errors = 0;
		mismatches  = 0;
		tests_ok    = 0;
		tests_bad   = 0;
	end

	// Inputs move on the rising edge, so the falling edge sees them settled
	always @(negedge clk_sys) begin
		if (sample) begin
			compare("nmi", {7'd0, exp_nmi}, {7'd0, nmi});
			compare("mf2_en", {7'd0, exp_en}, {7'd0, mf2_en});
			compare("rom_en", {7'd0, exp_rom}, {7'd0, rom_en});
			compare("ram_en", {7'd0, exp_ram}, {7'd0, ram_en});
			compare("dout", exp_dout, dout);
		end
		if (test_end) begin
			if (test_errors == 0) begin
				$display("test %0d ok", test_id);
				tests_ok++;
			end else begin
				$display("test %0d finished with %0d mismatches", test_id, test_errors);
				tests_bad++;
			end
			test_errors = 0;
		end
	end

endmodule

`default_nettype wire

/* bench/mf2_input.txt */
# test cmd addr data nmi mf2_en dout, all hex; cmd 0 reset (data is mode), 1 I/O write,
# 2 fetch, 3 NMI key, 4 mem write, 5 mem read, 6 check, 7/8 LCG write/read (data is count)
1 0 0000 00 0 0 FF
1 6 0000 00 0 0 FF
1 3 0000 00 1 0 FF
1 2 0066 00 0 1 FF
1 6 1234 00 0 1 FF
1 6 2345 00 0 1 FF
1 6 8000 00 0 1 FF
2 1 FEEA 00 0 0 FF
2 1 FEE8 00 0 1 FF
2 2 0065 00 0 1 FF
2 1 FEEA 00 0 0 FF
2 1 FEE8 00 0 0 FF
3 3 0000 00 1 0 FF
3 2 0066 00 0 1 FF
3 1 7F00 05 0 1 FF
3 1 7F00 4A 0 1 FF
3 1 BC00 0C 0 1 FF
3 1 BD00 30 0 1 FF
3 5 3FCF 00 0 1 05
3 5 3F95 00 0 1 4A
3 5 3CFF 00 0 1 0C
3 5 3DBC 00 0 1 30
4 4 2010 5A 0 1 FF
4 5 2010 00 0 1 5A
4 7 2000 80 0 1 FF
4 8 2000 80 0 1 00
4 1 FEEA 00 0 0 FF
4 5 2010 00 0 0 FF
5 0 0000 02 0 0 FF
5 3 0000 00 0 0 FF
5 0 0000 01 0 0 FF
5 1 FEEA 00 0 0 FF
5 1 FEE8 00 0 0 FF
5 3 0000 00 1 0 FF
5 2 0066 00 0 1 FF
5 2 0065 00 0 1 FF
5 1 FEEA 00 0 0 FF
5 1 FEE8 00 0 0 FF
5 3 0000 00 1 0 FF
5 2 0066 00 0 1 FF

/* bench/tb_multiface_two.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mf2_defs.svh"

module tb_multiface_two;

	localparam int CLK_NS      = 100;
	localparam int STEP_CYCLES = 4;
	localparam int RST_CYCLES  = 16;
	localparam int MARGIN_NS   = 50_000;
	localparam int LCG_STRIDE  = 131; // Odd, so offsets never repeat inside 8 KB
	localparam logic [31:0] LCG_SEED = 32'h6397_079e;
	localparam int CMD_RESET  = 0;
	localparam int CMD_IO_WR  = 1;
	localparam int CMD_FETCH  = 2;
	localparam int CMD_KEY    = 3;
	localparam int CMD_MEM_WR = 4;
	localparam int CMD_MEM_RD = 5;
	localparam int CMD_CHECK  = 6;
	localparam int CMD_LCG_WR = 7; // Data column holds the byte count
	localparam int CMD_LCG_RD = 8;

	logic                   clk_sys, reset;
	logic [15:0]            cpu_addr;
	logic [7:0]             cpu_dout;
	logic                   m1, io_wr, mem_rd, mem_wr, key_nmi;
	logic [`MF2_RAM_AW-1:0] mem_addr;
	mf2_state_pkg::mode_t   mode;
	logic                   nmi, mf2_en, rom_en, ram_en;
	logic [7:0]             dout;

	logic       sample, test_end, exp_nmi, exp_en;
	logic [7:0] test_id, exp_dout;
	int         mismatches, tests_ok, tests_bad;
	int         steps, other_errors;
	longint     limit_ns;
	logic       armed;

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_NS / 2) clk_sys = ~clk_sys;
	end

	multiface_two u_multiface_two (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu_addr (cpu_addr),
		.cpu_dout (cpu_dout),
		.m1       (m1),
		.io_wr    (io_wr),
		.mem_rd   (mem_rd),
		.mem_wr   (mem_wr),
		.key_nmi  (key_nmi),
		.mem_addr (mem_addr),
		.mode     (mode),
		.nmi      (nmi),
		.mf2_en   (mf2_en),
		.rom_en   (rom_en),
		.ram_en   (ram_en),
		.dout     (dout)
	);

	mf2_checker u_checker (
		.clk_sys    (clk_sys),
		.sample     (sample),
		.test_end   (test_end),
		.test_id    (test_id),
		.cpu_addr   (cpu_addr),
		.exp_nmi    (exp_nmi),
		.exp_en     (exp_en),
		.exp_dout   (exp_dout),
		.nmi        (nmi),
		.mf2_en     (mf2_en),
		.rom_en     (rom_en),
		.ram_en     (ram_en),
		.dout       (dout),
		.mismatches (mismatches),
		.tests_ok   (tests_ok),
		.tests_bad  (tests_bad)
	);

	////////////////////
	// Step tasks
	////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Strobe high for three cycles, checked just before it drops
	task automatic bus_step(input int cmd, input logic [15:0] addr, input logic [7:0] data,
		input logic e_nmi, input logic e_en, input logic [7:0] e_dout);
		@(posedge clk_sys);
		cpu_addr <= addr;
		mem_addr <= addr[`MF2_RAM_AW-1:0];
		cpu_dout <= data;
		io_wr    <= (cmd == CMD_IO_WR);
		m1       <= (cmd == CMD_FETCH);
		key_nmi  <= (cmd == CMD_KEY);
		mem_wr   <= (cmd == CMD_MEM_WR);
		mem_rd   <= (cmd == CMD_MEM_RD);
		exp_nmi  <= e_nmi;
		exp_en   <= e_en;
		exp_dout <= e_dout;
		repeat (STEP_CYCLES - 2) @(posedge clk_sys);
		sample <= 1'b1;
		@(posedge clk_sys);
		sample  <= 1'b0;
		io_wr   <= 1'b0;
		m1      <= 1'b0;
		key_nmi <= 1'b0;
		mem_wr  <= 1'b0;
		mem_rd  <= 1'b0;
	endtask

	task automatic apply_reset(input logic [1:0] m);
		@(posedge clk_sys);
		reset <= 1'b1;
		mode  <= mf2_state_pkg::mode_t'(m);
		repeat (RST_CYCLES) @(posedge clk_sys);
		reset <= 1'b0;
	endtask

	// Same seed for both passes, so the read pass knows every byte
	task automatic lcg_pass(input logic [15:0] base, input int count, input bit rd,
		input logic e_nmi, input logic e_en);
		logic [31:0] s;
		logic [12:0] off;
		logic [15:0] a;
		int          i;
		s = LCG_SEED;
		for (i = 0; i < count; i++) begin
			s   = lcg_next(s);
			off = 13'(i * LCG_STRIDE);
			a   = {base[15:13], base[12:0] + off};
			if (rd)
				bus_step(CMD_MEM_RD, a, 8'h00, e_nmi, e_en, s[31:24]);
			else
				bus_step(CMD_MEM_WR, a, s[31:24], e_nmi, e_en, 8'hFF);
		end
	endtask

	task automatic end_test(input logic [7:0] next_id);
		@(posedge clk_sys);
		test_end <= 1'b1;
		@(posedge clk_sys);
		test_end <= 1'b0;
		test_id  <= next_id;
	endtask

	// Tallies the steps of the input file, or runs them
	task automatic play_file(input bit run, output int n_steps);
		int              fd, got;
		logic [31:0]     t, c, a, d, e_n, e_e, e_d;
		logic [8*96-1:0] text;
		logic [7:0]      cur;
		bit              started;
		n_steps = 0;
		started = 1'b0;
		cur     = 8'h00;
		fd = $fopen("bench/mf2_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file bench/mf2_input.txt");
			other_errors++;
		end
		while (fd != 0 && !$feof(fd)) begin
			text = '0;
			got  = $fgets(text, fd);
			got  = $sscanf(text, "%h %h %h %h %h %h %h", t, c, a, d, e_n, e_e, e_d);
			if (got == 7) begin
				n_steps += (c == CMD_RESET) ? 6 : 1; // Reset runs about five steps
				if (c == CMD_LCG_WR || c == CMD_LCG_RD)
					n_steps += d;
			end else if (got > 0 && run) begin
				$display("a line of the stimulus file has only %0d of its 7 columns", got);
				other_errors++;
			end
			if (got == 7 && run) begin
				if (started && t[7:0] != cur) begin
					end_test(t[7:0]);
				end else if (!started) begin
					@(posedge clk_sys);
					test_id <= t[7:0];
				end
				started = 1'b1;
				cur     = t[7:0];
				case (c)
					CMD_RESET: begin
						apply_reset(d[1:0]);
						bus_step(CMD_CHECK, 16'h0000, 8'h00, e_n[0], e_e[0], e_d[7:0]);
					end
					CMD_IO_WR, CMD_FETCH, CMD_KEY, CMD_MEM_WR, CMD_MEM_RD, CMD_CHECK:
						bus_step(c, a[15:0], d[7:0], e_n[0], e_e[0], e_d[7:0]);
					CMD_LCG_WR, CMD_LCG_RD:
						lcg_pass(a[15:0], d, c == CMD_LCG_RD, e_n[0], e_e[0]);
					default: begin
						$display("test %0d has a step with unknown command %0h", t, c);
						other_errors++;
					end
				endcase
			end
		end
		if (started)
			end_test(8'h00);
		if (fd != 0)
			$fclose(fd);
	endtask

	////////////////////
	// Run
	////////////////////

	initial begin
		reset        = 1'b1;
		mode         = mf2_state_pkg::MODE_ENABLED;
		cpu_addr     = 16'h0000;
		cpu_dout     = 8'h00;
		mem_addr     = '0;
		m1           = 1'b0;
		io_wr        = 1'b0;
		mem_rd       = 1'b0;
		mem_wr       = 1'b0;
		key_nmi      = 1'b0;
		sample       = 1'b0;
		test_end     = 1'b0;
		test_id      = 8'h00;
		exp_nmi      = 1'b0;
		exp_en       = 1'b0;
		exp_dout     = 8'hFF;
		other_errors = 0;
		armed        = 1'b0;
		play_file(1'b0, steps);
		limit_ns = longint'(steps) * STEP_CYCLES * CLK_NS + MARGIN_NS;
		armed    = 1'b1;
		if (other_errors == 0)
			play_file(1'b1, steps);
		@(posedge clk_sys);
		$display("tests run %0d, ok %0d, with mismatches %0d, mismatches %0d, other errors %0d",
			tests_ok + tests_bad, tests_ok, tests_bad, mismatches, other_errors);
		if (tests_bad == 0 && other_errors == 0 && tests_ok > 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// Watchdog sized from the step count of the file
	initial begin
		wait (armed);
		#(limit_ns);
		$display("watchdog expired, the run did not finish within %0d ns", limit_ns);
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* include/mf2_defs.svh */
`ifndef MF2_DEFS_SVH
`define MF2_DEFS_SVH

////////////////////
// Expansion RAM
////////////////////

`define MF2_RAM_AW 13 // 8 KB

// Opcode fetch addresses seen by the cartridge
`define MF2_NMI_VECTOR 16'h0066 // NMI entry, pages the cartridge in
`define MF2_EXIT_ADDR  16'h0065 // ROM exit, sets hidden

////////////////////
// I/O ports
////////////////////

`define MF2_PAGE_PORT     14'b11111110111010 // FEE8 / FEEA, bit 1 picks off
`define MF2_PORT_GA       8'h7F // Gate array
`define MF2_PORT_CRTC_SEL 8'hBC
`define MF2_PORT_CRTC_VAL 8'hBD
`define MF2_PORT_PPI      8'hF7 // 8255
`define MF2_PORT_ROMSEL   8'hDF // Upper ROM select

////////////////////
// Shadow locations at the top of the RAM
////////////////////

`define MF2_SHADOW_PEN_IDX   13'h1FCF
`define MF2_SHADOW_PEN_BASE  9'h1F9 // Pen colour, low nibble is the pen
`define MF2_SHADOW_BORDER    13'h1FDF
`define MF2_SHADOW_MODE      13'h1FEF
`define MF2_SHADOW_BANK      13'h1FFF
`define MF2_SHADOW_CRTC_SEL  13'h1CFF
`define MF2_SHADOW_CRTC_BASE 9'h1DB // CRTC value, low nibble is the register
`define MF2_SHADOW_PPI       13'h17FF
`define MF2_SHADOW_ROMSEL    13'h1AAC

`endif

/* src.f */
+incdir+include
verilog/mf2_bus_pkg.sv
verilog/mf2_state_pkg.sv
verilog/mf2_bus_decode.sv
verilog/mf2_control.sv
verilog/mf2_shadow_ram.sv
verilog/multiface_two.sv
bench/mf2_checker.sv
bench/tb_multiface_two.sv

/* verilog/mf2_bus_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mf2_defs.svh"

module mf2_bus_decode (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic [15:0]            cpu_addr,
	input  logic [7:0]             cpu_dout,
	input  logic                   io_wr,
	input  logic                   m1,
	input  logic                   key_nmi,
	output mf2_bus_pkg::cycle_t    cycle,
	output logic [`MF2_RAM_AW-1:0] store_addr,
	output logic                   key_rise,
	output logic                   fetch_vector,
	output logic                   fetch_exit
);

	logic                   io_wr_q, m1_q, key_q;
	logic                   io_rise, m1_rise;
	logic [4:0]             pen_index;   // Bit 4 selects the border
	logic [3:0]             crtc_reg;
	logic [`MF2_RAM_AW-1:0] store_addr_c;
	logic                   page_hit;

	assign io_rise  = io_wr & ~io_wr_q;
	assign m1_rise  = m1 & ~m1_q;
	assign page_hit = (cpu_addr[15:2] == `MF2_PAGE_PORT);

	////////////////////
	// Shadow location of the current write
	////////////////////

	always_comb begin
		store_addr_c = '0; // Zero means not a shadowed port
		case (cpu_addr[15:8])
			`MF2_PORT_GA: begin
				case (cpu_dout[7:6])
					2'b00: store_addr_c = `MF2_SHADOW_PEN_IDX;
					2'b01: store_addr_c = pen_index[4] ? `MF2_SHADOW_BORDER
						: {`MF2_SHADOW_PEN_BASE, pen_index[3:0]};
					2'b10: store_addr_c = `MF2_SHADOW_MODE;
					default: store_addr_c = `MF2_SHADOW_BANK;
				endcase
			end
			`MF2_PORT_CRTC_SEL: store_addr_c = `MF2_SHADOW_CRTC_SEL;
			`MF2_PORT_CRTC_VAL: store_addr_c = {`MF2_SHADOW_CRTC_BASE, crtc_reg};
			`MF2_PORT_PPI:      store_addr_c = `MF2_SHADOW_PPI;
			`MF2_PORT_ROMSEL:   store_addr_c = `MF2_SHADOW_ROMSEL;
			default:            store_addr_c = '0;
		endcase
	end

	////////////////////
	// Edge pulses
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q      <= 1'b0;
			m1_q         <= 1'b0;
			key_q        <= 1'b0;
			key_rise     <= 1'b0;
			fetch_vector <= 1'b0;
			fetch_exit   <= 1'b0;
			cycle        <= mf2_bus_pkg::CYC_NONE;
		end else begin
			io_wr_q      <= io_wr;
			m1_q         <= m1;
			key_q        <= key_nmi;
			key_rise     <= key_nmi & ~key_q;
			fetch_vector <= m1_rise && (cpu_addr == `MF2_NMI_VECTOR);
			fetch_exit   <= m1_rise && (cpu_addr == `MF2_EXIT_ADDR);
			if (!io_rise)
				cycle <= mf2_bus_pkg::CYC_NONE;
			else if (page_hit)
				cycle <= cpu_addr[1] ? mf2_bus_pkg::CYC_PAGE_OFF : mf2_bus_pkg::CYC_PAGE_ON;
			else if (|store_addr_c)
				cycle <= mf2_bus_pkg::CYC_STORE;
			else
				cycle <= mf2_bus_pkg::CYC_NONE;
		end
	end

	always_ff @(posedge clk_sys) begin
		store_addr <= store_addr_c; // Only looked at with a store pulse
	end

	// Pen and CRTC register follow the select writes
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pen_index <= '0;
			crtc_reg  <= '0;
		end else if (cycle == mf2_bus_pkg::CYC_STORE) begin
			if (store_addr == `MF2_SHADOW_PEN_IDX)
				pen_index <= cpu_dout[4:0]; // Data still held by the bus
			if (store_addr == `MF2_SHADOW_CRTC_SEL)
				crtc_reg <= cpu_dout[3:0];
		end
	end

	// Stores never point at location zero
	a_store_addr: assert property (@(posedge clk_sys) disable iff (reset)
		(cycle == mf2_bus_pkg::CYC_STORE) |-> (store_addr != '0));

endmodule

`default_nettype wire

/* verilog/mf2_bus_pkg.sv */
`default_nettype none

package mf2_bus_pkg;

	////////////////////
	// I/O write classes
	////////////////////

	// One of these leaves the decode stage per io_wr rise,
	// CYC_NONE on every other cycle
	typedef enum logic [1:0] {
		CYC_NONE     = 2'd0, // Nothing of interest
		CYC_PAGE_ON  = 2'd1, // Write to FEE8
		CYC_PAGE_OFF = 2'd2, // Write to FEEA
		CYC_STORE    = 2'd3  // Hardware register copy into shadow RAM
	} cycle_t;

	// True for either paging port
	function automatic logic is_page_cmd(input cycle_t c);
		logic hit;
		hit = (c == CYC_PAGE_ON) || (c == CYC_PAGE_OFF);
		return hit;
	endfunction

endpackage

`default_nettype wire

/* verilog/mf2_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mf2_defs.svh"

module mf2_control (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  mf2_state_pkg::mode_t mode,
	input  mf2_bus_pkg::cycle_t  cycle,
	input  logic                 key_rise,
	input  logic                 fetch_vector,
	input  logic                 fetch_exit,
	input  logic [15:0]          cpu_addr,
	output logic                 nmi,
	output logic                 mf2_en,
	output logic                 rom_en,
	output logic                 ram_en
);

	mf2_state_pkg::state_t state;
	mf2_state_pkg::mode_t  mode_q; // Held from the last reset
	logic                  hidden;

	////////////////////
	// Paging FSM
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state  <= mf2_state_pkg::ST_IDLE;
			mode_q <= mode;
			hidden <= mf2_state_pkg::starts_hidden(mode);
		end else begin
			case (state)
				mf2_state_pkg::ST_IDLE: begin
					if (key_rise && mode_q != mf2_state_pkg::MODE_DISABLED)
						state <= mf2_state_pkg::ST_NMI_PEND;
					else if (cycle == mf2_bus_pkg::CYC_PAGE_ON && !hidden)
						state <= mf2_state_pkg::ST_ACTIVE; // Ignored while hidden
				end
				mf2_state_pkg::ST_NMI_PEND: begin
					if (fetch_vector) begin
						state  <= mf2_state_pkg::ST_ACTIVE;
						hidden <= 1'b0; // Entry always reveals the cartridge
					end
				end
				mf2_state_pkg::ST_ACTIVE: begin
					if (cycle == mf2_bus_pkg::CYC_PAGE_OFF)
						state <= mf2_state_pkg::ST_IDLE;
					if (fetch_exit)
						hidden <= 1'b1;
				end
				default: state <= mf2_state_pkg::ST_IDLE;
			endcase
		end
	end

	assign nmi    = (state == mf2_state_pkg::ST_NMI_PEND);
	assign mf2_en = (state == mf2_state_pkg::ST_ACTIVE);

	////////////////////
	// Memory map
	////////////////////

	assign rom_en = mf2_en && (cpu_addr[15:13] == 3'b000); // 0000-1FFF
	assign ram_en = mf2_en && (cpu_addr[15:13] == 3'b001); // 2000-3FFF

	// Cartridge is never paged in while its NMI is still pending
	a_nmi_en: assert property (@(posedge clk_sys) disable iff (reset)
		!(nmi && mf2_en));
	a_rom_ram: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0({rom_en, ram_en}));

endmodule

`default_nettype wire

/* verilog/mf2_shadow_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mf2_defs.svh"

module mf2_shadow_ram (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  mf2_bus_pkg::cycle_t    cycle,
	input  logic [`MF2_RAM_AW-1:0] store_addr,
	input  logic [7:0]             cpu_dout,
	input  logic [`MF2_RAM_AW-1:0] mem_addr,
	input  logic                   mem_wr,
	input  logic                   mem_rd,
	input  logic                   ram_en,
	output logic [7:0]             dout
);

	localparam int DEPTH = 1 << `MF2_RAM_AW;

	logic [7:0]             mem [0:DEPTH-1];
	logic [`MF2_RAM_AW-1:0] ram_a;
	logic [7:0]             ram_in;
	logic [7:0]             ram_out;
	logic                   ram_we;
	logic                   store;
	logic                   cpu_we;

	assign store  = (cycle == mf2_bus_pkg::CYC_STORE);
	assign cpu_we = mem_wr & ram_en;

	////////////////////
	// Port selection
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset)
			ram_we <= 1'b0;
		else
			ram_we <= store | cpu_we;
	end

	// Shadow store wins over the processor
	always_ff @(posedge clk_sys) begin
		if (store) begin
			ram_a  <= store_addr;
			ram_in <= cpu_dout;
		end else if (cpu_we) begin
			ram_a  <= mem_addr;
			ram_in <= cpu_dout;
		end else begin
			ram_a <= mem_addr; // Plain read
		end
	end

	////////////////////
	// Storage
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mem[ram_a] <= ram_in;
			ram_out    <= ram_in; // Write-through to the read register
		end else begin
			ram_out <= mem[ram_a];
		end
	end

	// Open bus reads as FF, the processor ANDs all sources
	assign dout = (ram_en & mem_rd) ? ram_out : 8'hFF;

endmodule

`default_nettype wire

/* verilog/mf2_state_pkg.sv */
`default_nettype none

package mf2_state_pkg;

	////////////////////
	// Paging FSM
	////////////////////

	typedef enum logic [1:0] {
		ST_IDLE     = 2'd0, // Cartridge paged out
		ST_NMI_PEND = 2'd1, // NMI raised, waiting for the 0066h fetch
		ST_ACTIVE   = 2'd2  // ROM and RAM mapped into the low 16 KB
	} state_t;

	////////////////////
	// Configuration
	////////////////////

	typedef enum logic [1:0] {
		MODE_ENABLED  = 2'd0,
		MODE_HIDDEN   = 2'd1, // Paging ports ignored until first NMI entry
		MODE_DISABLED = 2'd2  // Key never raises NMI
	} mode_t;

	// Anything but enabled comes out of reset hidden
	function automatic logic starts_hidden(input mode_t m);
		logic h;
		h = (m != MODE_ENABLED);
		return h;
	endfunction

endpackage

`default_nettype wire

/* verilog/multiface_two.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mf2_defs.svh"

module multiface_two (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic [15:0]            cpu_addr,
	input  logic [7:0]             cpu_dout,
	input  logic                   m1,
	input  logic                   io_wr,
	input  logic                   mem_rd,
	input  logic                   mem_wr,
	input  logic                   key_nmi,
	input  logic [`MF2_RAM_AW-1:0] mem_addr,   // Low bits of the memory address
	input  mf2_state_pkg::mode_t   mode,       // Sampled during reset
	output logic                   nmi,
	output logic                   mf2_en,
	output logic                   rom_en,
	output logic                   ram_en,
	output logic [7:0]             dout
);

	mf2_bus_pkg::cycle_t    cycle;
	logic [`MF2_RAM_AW-1:0] store_addr;
	logic                   key_rise, fetch_vector, fetch_exit;

	mf2_bus_decode u_decode (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cpu_addr     (cpu_addr),
		.cpu_dout     (cpu_dout),
		.io_wr        (io_wr),
		.m1           (m1),
		.key_nmi      (key_nmi),
		.cycle        (cycle),
		.store_addr   (store_addr),
		.key_rise     (key_rise),
		.fetch_vector (fetch_vector),
		.fetch_exit   (fetch_exit)
	);

	mf2_control u_control (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.mode         (mode),
		.cycle        (cycle),
		.key_rise     (key_rise),
		.fetch_vector (fetch_vector),
		.fetch_exit   (fetch_exit),
		.cpu_addr     (cpu_addr),
		.nmi          (nmi),
		.mf2_en       (mf2_en),
		.rom_en       (rom_en),
		.ram_en       (ram_en)
	);

	mf2_shadow_ram u_ram (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cycle      (cycle),
		.store_addr (store_addr),
		.cpu_dout   (cpu_dout),
		.mem_addr   (mem_addr),
		.mem_wr     (mem_wr),
		.mem_rd     (mem_rd),
		.ram_en     (ram_en),
		.dout       (dout)
	);

endmodule

`default_nettype wire
